//--- logic/tlb_pkg.sv
package tlb_pkg;

  // ------------------------------
  // Sv39 address geometry
  // ------------------------------
  localparam int VADDR_W     = 39;
  localparam int PADDR_W     = 56;
  localparam int PG_IDX_W    = 12;
  localparam int VPN_W       = 27;
  localparam int PPN_W       = 44;
  localparam int PG_LEVELS   = 3;
  localparam int PG_LEVEL_W  = 9;
  localparam int LEVEL_W     = 2;

  // ------------------------------
  // TLB sizing
  // ------------------------------
  localparam int TLB_ENTRIES = 8;
  localparam int ENTRY_IDX_W = $clog2(TLB_ENTRIES);

  typedef logic [VPN_W-1:0]   vpn_t;
  typedef logic [PPN_W-1:0]   ppn_t;
  // 0 is a 4 KiB page, 1 a 2 MiB page, 2 a 1 GiB page
  typedef logic [LEVEL_W-1:0] level_t;

  typedef enum logic [1:0] {
    CMD_LOAD  = 2'd0,
    CMD_STORE = 2'd1,
    CMD_FETCH = 2'd2
  } cmd_t;

  // log2 of the access size in bytes
  typedef logic [1:0] size_t;

  typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_S = 2'd1,
    PRV_M = 2'd3
  } prv_t;

  typedef struct packed {
    logic u;
    logic r;
    logic w;
    logic x;
  } pte_flags_t;

  typedef struct packed {
    logic       valid;
    level_t     level;
    vpn_t       vpn;
    ppn_t       ppn;
    pte_flags_t flags;
  } tlb_entry_t;

  typedef enum logic [1:0] {
    ST_IDLE         = 2'd0,
    ST_WALK         = 2'd1,
    ST_WALK_FLUSHED = 2'd2
  } walk_state_t;

  // payload of one translation response, valid travels beside it
  typedef struct packed {
    logic [PADDR_W-1:0] paddr;
    logic               miss;
    logic               pf_ld;
    logic               pf_st;
    logic               pf_inst;
    logic               ma_ld;
    logic               ma_st;
  } tlb_resp_t;

endpackage

//--- logic/tlb_dec_if.sv
`timescale 1ns/1ps

interface tlb_dec_if
  import tlb_pkg::*;
();

  logic               valid;
  logic [VADDR_W-1:0] vaddr;
  vpn_t               vpn;
  cmd_t               cmd;
  prv_t               prv;
  logic               misaligned;
  // translation applies to this request
  logic               vm_on;

  // decode stage drives the registered request
  modport src (
    output valid, vaddr, vpn, cmd, prv, misaligned, vm_on
  );

  // lookup and response stages only observe it
  modport dst (
    input valid, vaddr, vpn, cmd, prv, misaligned, vm_on
  );

endinterface

//--- logic/tlb_hit_if.sv
`timescale 1ns/1ps

interface tlb_hit_if
  import tlb_pkg::*;
();

  logic       hit;
  logic       miss;
  // fields of the matching entry, zero when nothing hits
  ppn_t       ppn;
  level_t     level;
  pte_flags_t flags;

  // lookup stage produces these combinationally
  modport src (
    output hit, miss, ppn, level, flags
  );

  // response stage registers them
  modport dst (
    input hit, miss, ppn, level, flags
  );

endinterface

//--- logic/oh_select.sv
`timescale 1ns/1ps

module oh_select #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  T                   i_data [WORDS],
  input  logic [WORDS-1:0]   i_oh,
  output T                   o_selected
);

  T w_acc;

  // or of every word whose select bit is set
  always_comb begin
    w_acc = T'(0);
    for (int i = 0; i < WORDS; i++) begin
      if (i_oh[i]) begin
        w_acc = T'(w_acc | i_data[i]);
      end
    end
  end

  // a non one-hot select merges words, caller guarantees one-hot or zero
  assign o_selected = w_acc;

endmodule

//--- logic/tlb_req_decode.sv
`timescale 1ns/1ps

module tlb_req_decode
  import tlb_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_req_valid,
  input  logic [VADDR_W-1:0] i_req_vaddr,
  input  cmd_t               i_req_cmd,
  input  size_t              i_req_size,

  input  prv_t               i_status_prv,
  input  logic               i_satp_mode_on,

  tlb_dec_if.src             o_dec
);

  logic [2:0]         w_size_mask;
  logic               w_misaligned;
  logic               w_vm_on;

  logic               r_valid;
  logic [VADDR_W-1:0] r_vaddr;
  cmd_t               r_cmd;
  prv_t               r_prv;
  logic               r_misaligned;
  logic               r_vm_on;

  // byte offset bits that must be zero for the given size
  assign w_size_mask  = 3'b111 >> (2'd3 - i_req_size);
  assign w_misaligned = |(i_req_vaddr[2:0] & w_size_mask);

  // machine mode always bypasses translation
  assign w_vm_on = i_satp_mode_on && (i_status_prv != PRV_M);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_vaddr      <= i_req_vaddr;
    r_cmd        <= i_req_cmd;
    r_prv        <= i_status_prv;
    r_misaligned <= w_misaligned;
    r_vm_on      <= w_vm_on;
  end

  assign o_dec.valid      = r_valid;
  assign o_dec.vaddr      = r_vaddr;
  assign o_dec.vpn        = r_vaddr[VADDR_W-1:PG_IDX_W];
  assign o_dec.cmd        = r_cmd;
  assign o_dec.prv        = r_prv;
  assign o_dec.misaligned = r_misaligned;
  assign o_dec.vm_on      = r_vm_on;

endmodule

//--- logic/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup
  import tlb_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  logic        i_sfence_valid,

  input  logic        i_ptw_resp_valid,
  input  vpn_t        i_ptw_resp_vpn,
  input  ppn_t        i_ptw_resp_ppn,
  input  level_t      i_ptw_resp_level,
  input  pte_flags_t  i_ptw_resp_flags,

  tlb_dec_if.dst      i_dec,

  output logic        o_ptw_req_valid,
  output vpn_t        o_ptw_req_vpn,

  tlb_hit_if.src      o_hit
);

  tlb_entry_t                  r_entries [TLB_ENTRIES];
  logic [ENTRY_IDX_W-1:0]      r_victim;
  walk_state_t                 r_state;
  logic                        r_walk_open;

  logic [TLB_ENTRIES-1:0]      w_hit_vec;
  logic                        w_hit;
  logic                        w_miss;
  logic                        w_refill;
  logic [ENTRY_IDX_W-1:0]      w_hit_idx;
  ppn_t                        w_entry_ppn [TLB_ENTRIES];
  pte_flags_t                  w_entry_flags [TLB_ENTRIES];

  // ------------------------------
  // level-aware tag match
  // ------------------------------
  for (genvar e = 0; e < TLB_ENTRIES; e++) begin : g_entry
    logic [PG_LEVELS-1:0] w_field_match;

    for (genvar lvl = 0; lvl < PG_LEVELS; lvl++) begin : g_level
      // superpages ignore the vpn fields below their level
      assign w_field_match[lvl] =
        (r_entries[e].level > level_t'(lvl)) ||
        (r_entries[e].vpn[lvl*PG_LEVEL_W +: PG_LEVEL_W] ==
         i_dec.vpn[lvl*PG_LEVEL_W +: PG_LEVEL_W]);
    end

    assign w_hit_vec[e]     = r_entries[e].valid && i_dec.vm_on && (&w_field_match);
    assign w_entry_ppn[e]   = r_entries[e].ppn;
    assign w_entry_flags[e] = r_entries[e].flags;
  end

  assign w_hit  = |w_hit_vec;
  assign w_miss = i_dec.valid && i_dec.vm_on && !w_hit;

  oh_select #(.T(ppn_t), .WORDS(TLB_ENTRIES)) u_ppn_sel (
    .i_data     (w_entry_ppn),
    .i_oh       (w_hit_vec),
    .o_selected (o_hit.ppn)
  );

  oh_select #(.T(pte_flags_t), .WORDS(TLB_ENTRIES)) u_flags_sel (
    .i_data     (w_entry_flags),
    .i_oh       (w_hit_vec),
    .o_selected (o_hit.flags)
  );

  // index of the hitting entry when there is a hit
  always_comb begin
    w_hit_idx = '0;
    for (int e = 0; e < TLB_ENTRIES; e++) begin
      if (w_hit_vec[e]) begin
        w_hit_idx = ENTRY_IDX_W'(e);
      end
    end
  end

  assign o_hit.hit   = w_hit;
  assign o_hit.miss  = w_miss;
  assign o_hit.level = w_hit ? r_entries[w_hit_idx].level : '0;

  // ------------------------------
  // walk FSM
  // ------------------------------
  // only one walk at a time so later misses just report miss
  assign o_ptw_req_valid = w_miss && (r_state == ST_IDLE);
  assign o_ptw_req_vpn   = i_dec.vpn;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (o_ptw_req_valid) begin
            r_state <= i_sfence_valid ? ST_WALK_FLUSHED : ST_WALK;
          end
        end
        ST_WALK: begin
          if (i_ptw_resp_valid) begin
            r_state <= ST_IDLE;
          end else if (i_sfence_valid) begin
            r_state <= ST_WALK_FLUSHED;
          end
        end
        ST_WALK_FLUSHED: begin
          // the answer belongs to a fenced mapping and is dropped
          if (i_ptw_resp_valid) begin
            r_state <= ST_IDLE;
          end
        end
        default: begin
          r_state <= ST_IDLE;
        end
      endcase
    end
  end

  // set by a walk request and cleared by the walker answer
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_walk_open <= 1'b0;
    end else if (o_ptw_req_valid) begin
      r_walk_open <= 1'b1;
    end else if (i_ptw_resp_valid) begin
      r_walk_open <= 1'b0;
    end
  end

  // ------------------------------
  // refill, replacement and fence
  // ------------------------------
  assign w_refill = i_ptw_resp_valid && (r_state == ST_WALK);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < TLB_ENTRIES; e++) begin
        r_entries[e] <= '0;
      end
      r_victim <= '0;
    end else begin
      if (w_refill) begin
        r_entries[r_victim] <= '{valid: 1'b1,
                                 level: i_ptw_resp_level,
                                 vpn:   i_ptw_resp_vpn,
                                 ppn:   i_ptw_resp_ppn,
                                 flags: i_ptw_resp_flags};
        // round robin
        r_victim <= r_victim + 1'b1;
      end
      // fence wins over a refill in the same cycle
      if (i_sfence_valid) begin
        for (int e = 0; e < TLB_ENTRIES; e++) begin
          r_entries[e].valid <= 1'b0;
        end
      end
    end
  end

  a_hit_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_dec.valid |-> $onehot0(w_hit_vec))
    else $error("multiple TLB entries hit");

  a_one_walk: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ptw_req_valid |-> !r_walk_open)
    else $error("walk request while a walk is outstanding");

endmodule

//--- logic/tlb_resp_gen.sv
`timescale 1ns/1ps

module tlb_resp_gen
  import tlb_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  input  logic               i_status_sum,
  input  logic               i_status_mxr,

  tlb_dec_if.dst             i_dec,
  tlb_hit_if.dst             i_hit,

  output logic               o_resp_valid,
  output logic [PADDR_W-1:0] o_resp_paddr,
  output logic               o_resp_miss,
  output logic               o_resp_pf_ld,
  output logic               o_resp_pf_st,
  output logic               o_resp_pf_inst,
  output logic               o_resp_ma_ld,
  output logic               o_resp_ma_st
);

  ppn_t      w_ppn;
  logic      w_priv_ok;
  logic      w_readable;
  tlb_resp_t w_resp;

  logic      r_valid;
  tlb_resp_t r_resp;

  // superpage ppn takes its low fields from the vaddr
  always_comb begin
    w_ppn = i_hit.ppn;
    for (int lvl = 0; lvl < PG_LEVELS - 1; lvl++) begin
      if (i_hit.level > level_t'(lvl)) begin
        w_ppn[lvl*PG_LEVEL_W +: PG_LEVEL_W] =
          i_dec.vaddr[PG_IDX_W + lvl*PG_LEVEL_W +: PG_LEVEL_W];
      end
    end
  end

  // sum only opens user pages to loads and stores, never to fetch
  assign w_priv_ok = ((i_dec.prv == PRV_S) && !i_hit.flags.u) ||
                     ((i_dec.prv == PRV_S) && i_status_sum && i_hit.flags.u &&
                      (i_dec.cmd != CMD_FETCH)) ||
                     ((i_dec.prv == PRV_U) && i_hit.flags.u);

  assign w_readable = i_hit.flags.r || (i_hit.flags.x && i_status_mxr);

  always_comb begin
    w_resp.paddr   = i_dec.vm_on ? {w_ppn, i_dec.vaddr[PG_IDX_W-1:0]}
                                 : PADDR_W'(i_dec.vaddr);
    w_resp.miss    = i_hit.miss;
    w_resp.pf_ld   = i_hit.hit && (i_dec.cmd == CMD_LOAD) && (!w_priv_ok || !w_readable);
    w_resp.pf_st   = i_hit.hit && (i_dec.cmd == CMD_STORE) && (!w_priv_ok || !i_hit.flags.w);
    w_resp.pf_inst = i_hit.hit && (i_dec.cmd == CMD_FETCH) && (!w_priv_ok || !i_hit.flags.x);
    w_resp.ma_ld   = i_dec.misaligned && (i_dec.cmd == CMD_LOAD);
    w_resp.ma_st   = i_dec.misaligned && (i_dec.cmd == CMD_STORE);
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_dec.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_resp <= w_resp;
  end

  assign o_resp_valid   = r_valid;
  assign o_resp_paddr   = r_resp.paddr;
  assign o_resp_miss    = r_resp.miss;
  assign o_resp_pf_ld   = r_resp.pf_ld;
  assign o_resp_pf_st   = r_resp.pf_st;
  assign o_resp_pf_inst = r_resp.pf_inst;
  assign o_resp_ma_ld   = r_resp.ma_ld;
  assign o_resp_ma_st   = r_resp.ma_st;

  a_miss_no_pf: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_resp_valid |-> !(o_resp_miss && (o_resp_pf_ld || o_resp_pf_st || o_resp_pf_inst)))
    else $error("response shows miss and page fault together");

endmodule

//--- logic/tlb_top.sv
`timescale 1ns/1ps

module tlb_top
  import tlb_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  // request
  input  logic               i_req_valid,
  input  logic [VADDR_W-1:0] i_req_vaddr,
  input  cmd_t               i_req_cmd,
  input  size_t              i_req_size,

  // status
  input  prv_t               i_status_prv,
  input  logic               i_status_sum,
  input  logic               i_status_mxr,
  input  logic               i_satp_mode_on,
  input  logic               i_sfence_valid,

  // page table walker
  output logic               o_ptw_req_valid,
  output vpn_t               o_ptw_req_vpn,
  input  logic               i_ptw_resp_valid,
  input  vpn_t               i_ptw_resp_vpn,
  input  ppn_t               i_ptw_resp_ppn,
  input  level_t             i_ptw_resp_level,
  input  pte_flags_t         i_ptw_resp_flags,

  // response, two cycles after the request
  output logic               o_resp_valid,
  output logic [PADDR_W-1:0] o_resp_paddr,
  output logic               o_resp_miss,
  output logic               o_resp_pf_ld,
  output logic               o_resp_pf_st,
  output logic               o_resp_pf_inst,
  output logic               o_resp_ma_ld,
  output logic               o_resp_ma_st
);

  tlb_dec_if dec_if ();
  tlb_hit_if hit_if ();

  tlb_req_decode u_decode (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_req_valid    (i_req_valid),
    .i_req_vaddr    (i_req_vaddr),
    .i_req_cmd      (i_req_cmd),
    .i_req_size     (i_req_size),
    .i_status_prv   (i_status_prv),
    .i_satp_mode_on (i_satp_mode_on),
    .o_dec          (dec_if)
  );

  tlb_lookup u_lookup (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_sfence_valid   (i_sfence_valid),
    .i_ptw_resp_valid (i_ptw_resp_valid),
    .i_ptw_resp_vpn   (i_ptw_resp_vpn),
    .i_ptw_resp_ppn   (i_ptw_resp_ppn),
    .i_ptw_resp_level (i_ptw_resp_level),
    .i_ptw_resp_flags (i_ptw_resp_flags),
    .i_dec            (dec_if),
    .o_ptw_req_valid  (o_ptw_req_valid),
    .o_ptw_req_vpn    (o_ptw_req_vpn),
    .o_hit            (hit_if)
  );

  tlb_resp_gen u_resp_gen (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_status_sum   (i_status_sum),
    .i_status_mxr   (i_status_mxr),
    .i_dec          (dec_if),
    .i_hit          (hit_if),
    .o_resp_valid   (o_resp_valid),
    .o_resp_paddr   (o_resp_paddr),
    .o_resp_miss    (o_resp_miss),
    .o_resp_pf_ld   (o_resp_pf_ld),
    .o_resp_pf_st   (o_resp_pf_st),
    .o_resp_pf_inst (o_resp_pf_inst),
    .o_resp_ma_ld   (o_resp_ma_ld),
    .o_resp_ma_st   (o_resp_ma_st)
  );

endmodule

//--- verification/tb_tlb_table.svh
// ------------------------------
// pages and expected faults
// ------------------------------
localparam ppn_t PPN_A = 44'h123456;
localparam ppn_t PPN_B = 44'h2468A;
// low fields set so superpage replacement shows
localparam ppn_t PPN_C = 44'h55501FF;
localparam ppn_t PPN_D = 44'hABC3FFFF;
localparam ppn_t PPN_E = 44'h77001;
localparam ppn_t PPN_F = 44'h77002;
localparam ppn_t PPN_G = 44'h77003;

// flags are {u, r, w, x}
localparam pte_flags_t FL_S_RW   = 4'b0110;
localparam pte_flags_t FL_S_RWX  = 4'b0111;
localparam pte_flags_t FL_U_RWX  = 4'b1111;
localparam pte_flags_t FL_S_R    = 4'b0100;
localparam pte_flags_t FL_S_X    = 4'b0001;

localparam logic [4:0] F_NONE    = 5'b00000;
localparam logic [4:0] F_PF_LD   = 5'b10000;
localparam logic [4:0] F_PF_ST   = 5'b01000;
localparam logic [4:0] F_PF_INST = 5'b00100;
localparam logic [4:0] F_MA_LD   = 5'b00010;
localparam logic [4:0] F_MA_ST   = 5'b00001;

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
  checks++;
  if (got !== expected) begin
    errors++;
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
  end
endtask

task automatic build_table();
  logic [VADDR_W-1:0] va_a;
  logic [VADDR_W-1:0] va_b;
  logic [VADDR_W-1:0] va_c;
  logic [VADDR_W-1:0] va_d;
  logic [VADDR_W-1:0] va_e;
  logic [VADDR_W-1:0] va_f;
  logic [VADDR_W-1:0] va_g;
  logic [VADDR_W-1:0] va;
  va_a = make_vaddr(9'd1, 9'd2, 9'd3, 12'h100);
  va_b = make_vaddr(9'd1, 9'd2, 9'd5, 12'h040);
  va_c = make_vaddr(9'd2, 9'd7, 9'd9, 12'h010);
  va_d = make_vaddr(9'd3, 9'h010, 9'h020, 12'h008);
  va_e = make_vaddr(9'd4, 9'd0, 9'd1, 12'h200);
  va_f = make_vaddr(9'd4, 9'd0, 9'd2, 12'h300);
  va_g = make_vaddr(9'd4, 9'd0, 9'd3, 12'h400);

  // bare, satp off or machine mode
  set_status(PRV_S, 1'b0, 1'b0, 1'b0);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b0, PADDR_W'(va_a), F_NONE, 1'b0);
  va = va_a | 39'h4;
  request_row(va, CMD_LOAD, 2'd3, 1'b0, PADDR_W'(va), F_MA_LD, 1'b0);
  set_status(PRV_M, 1'b0, 1'b0, 1'b1);
  request_row(va_c, CMD_STORE, 2'd2, 1'b0, PADDR_W'(va_c), F_NONE, 1'b0);
  set_status(PRV_U, 1'b0, 1'b0, 1'b0);
  request_row(va_g, CMD_FETCH, 2'd1, 1'b0, PADDR_W'(va_g), F_NONE, 1'b0);

  // miss, second miss during the walk, refill
  set_status(PRV_S, 1'b0, 1'b0, 1'b1);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  request_row(va_b, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b0);
  refill_row(va_a[VADDR_W-1:PG_IDX_W], PPN_A, 2'd0, FL_S_RW);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_A, 2'd0, va_a), F_NONE, 1'b0);
  request_row(va_b, CMD_STORE, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_b[VADDR_W-1:PG_IDX_W], PPN_B, 2'd0, FL_S_RW);
  request_row(va_b, CMD_STORE, 2'd3, 1'b0, map_paddr(PPN_B, 2'd0, va_b), F_NONE, 1'b0);

  // 2 MiB and 1 GiB pages
  request_row(va_c, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_c[VADDR_W-1:PG_IDX_W], PPN_C, 2'd1, FL_S_RW);
  va = make_vaddr(9'd2, 9'd7, 9'h1AB, 12'hFF8);
  request_row(va, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_C, 2'd1, va), F_NONE, 1'b0);
  va = make_vaddr(9'd2, 9'd7, 9'd0, 12'h000);
  request_row(va, CMD_STORE, 2'd3, 1'b0, map_paddr(PPN_C, 2'd1, va), F_NONE, 1'b0);
  request_row(va_d, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_d[VADDR_W-1:PG_IDX_W], PPN_D, 2'd2, FL_S_RWX);
  va = make_vaddr(9'd3, 9'h1FF, 9'h155, 12'hABC);
  request_row(va, CMD_FETCH, 2'd2, 1'b0, map_paddr(PPN_D, 2'd2, va), F_NONE, 1'b0);
  for (int i = 0; i < RANDOM_ROWS; i++) begin
    va = make_vaddr(9'd2, 9'd7, 9'($random(seed)), 12'($random(seed)));
    request_row(va, CMD_LOAD, 2'd0, 1'b0, map_paddr(PPN_C, 2'd1, va), F_NONE, 1'b0);
    va = make_vaddr(9'd3, 9'($random(seed)), 9'($random(seed)), 12'($random(seed)));
    request_row(va, CMD_STORE, 2'd0, 1'b0, map_paddr(PPN_D, 2'd2, va), F_NONE, 1'b0);
  end

  // user page from supervisor, with and without SUM
  request_row(va_e, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_e[VADDR_W-1:PG_IDX_W], PPN_E, 2'd0, FL_U_RWX);
  request_row(va_e, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_E, 2'd0, va_e), F_PF_LD, 1'b0);
  set_status(PRV_S, 1'b1, 1'b0, 1'b1);
  request_row(va_e, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_E, 2'd0, va_e), F_NONE, 1'b0);
  request_row(va_e, CMD_STORE, 2'd3, 1'b0, map_paddr(PPN_E, 2'd0, va_e), F_NONE, 1'b0);
  request_row(va_e, CMD_FETCH, 2'd2, 1'b0, map_paddr(PPN_E, 2'd0, va_e), F_PF_INST, 1'b0);
  set_status(PRV_U, 1'b0, 1'b0, 1'b1);
  request_row(va_e, CMD_FETCH, 2'd2, 1'b0, map_paddr(PPN_E, 2'd0, va_e), F_NONE, 1'b0);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_A, 2'd0, va_a), F_PF_LD, 1'b0);

  // read-only and execute-only pages
  set_status(PRV_S, 1'b0, 1'b0, 1'b1);
  request_row(va_f, CMD_STORE, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_f[VADDR_W-1:PG_IDX_W], PPN_F, 2'd0, FL_S_R);
  request_row(va_f, CMD_STORE, 2'd3, 1'b0, map_paddr(PPN_F, 2'd0, va_f), F_PF_ST, 1'b0);
  request_row(va_f, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_F, 2'd0, va_f), F_NONE, 1'b0);
  request_row(va_a, CMD_FETCH, 2'd2, 1'b0, map_paddr(PPN_A, 2'd0, va_a), F_PF_INST, 1'b0);
  request_row(va_g, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  refill_row(va_g[VADDR_W-1:PG_IDX_W], PPN_G, 2'd0, FL_S_X);
  request_row(va_g, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_G, 2'd0, va_g), F_PF_LD, 1'b0);
  set_status(PRV_S, 1'b0, 1'b1, 1'b1);
  request_row(va_g, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_G, 2'd0, va_g), F_NONE, 1'b0);
  request_row(va_g, CMD_FETCH, 2'd2, 1'b0, map_paddr(PPN_G, 2'd0, va_g), F_NONE, 1'b0);

  // misalignment on a hitting page
  set_status(PRV_S, 1'b0, 1'b0, 1'b1);
  va = va_a | 39'h1;
  request_row(va, CMD_LOAD, 2'd1, 1'b0, map_paddr(PPN_A, 2'd0, va), F_MA_LD, 1'b0);
  va = va_a | 39'h2;
  request_row(va, CMD_STORE, 2'd2, 1'b0, map_paddr(PPN_A, 2'd0, va), F_MA_ST, 1'b0);
  va = va_a | 39'h8;
  request_row(va, CMD_STORE, 2'd3, 1'b0, map_paddr(PPN_A, 2'd0, va), F_NONE, 1'b0);
  va = va_a | 39'h4;
  request_row(va, CMD_LOAD, 2'd2, 1'b0, map_paddr(PPN_A, 2'd0, va), F_NONE, 1'b0);

  // fence, then a fence during an outstanding walk
  fence_row();
  request_row(va_a, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  request_row(va_c, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b0);
  refill_row(va_a[VADDR_W-1:PG_IDX_W], PPN_A, 2'd0, FL_S_RW);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b0, map_paddr(PPN_A, 2'd0, va_a), F_NONE, 1'b0);
  request_row(va_d, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  fence_row();
  refill_row(va_d[VADDR_W-1:PG_IDX_W], PPN_D, 2'd2, FL_S_RWX);
  request_row(va_d, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b1);
  request_row(va_a, CMD_LOAD, 2'd3, 1'b1, '0, F_NONE, 1'b0);
endtask

//--- verification/tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb
  import tlb_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_ROWS  = 6;

  typedef enum logic [1:0] {
    OP_REQ,
    OP_REFILL,
    OP_FENCE
  } op_t;

  // fault bits are {pf_ld, pf_st, pf_inst, ma_ld, ma_st}
  typedef struct packed {
    op_t                op;
    logic [VADDR_W-1:0] vaddr;
    cmd_t               cmd;
    size_t              size;
    prv_t               prv;
    logic               sum;
    logic               mxr;
    logic               satp;
    vpn_t               fill_vpn;
    ppn_t               fill_ppn;
    level_t             fill_level;
    pte_flags_t         fill_flags;
    logic               exp_miss;
    logic [PADDR_W-1:0] exp_paddr;
    logic [4:0]         exp_faults;
    logic               exp_walk;
  } row_t;

  logic               i_clk;
  logic               i_reset_n;
  logic               i_req_valid;
  logic [VADDR_W-1:0] i_req_vaddr;
  cmd_t               i_req_cmd;
  size_t              i_req_size;
  prv_t               i_status_prv;
  logic               i_status_sum;
  logic               i_status_mxr;
  logic               i_satp_mode_on;
  logic               i_sfence_valid;
  logic               o_ptw_req_valid;
  vpn_t               o_ptw_req_vpn;
  logic               i_ptw_resp_valid;
  vpn_t               i_ptw_resp_vpn;
  ppn_t               i_ptw_resp_ppn;
  level_t             i_ptw_resp_level;
  pte_flags_t         i_ptw_resp_flags;
  logic               o_resp_valid;
  logic [PADDR_W-1:0] o_resp_paddr;
  logic               o_resp_miss;
  logic               o_resp_pf_ld;
  logic               o_resp_pf_st;
  logic               o_resp_pf_inst;
  logic               o_resp_ma_ld;
  logic               o_resp_ma_st;

  int   errors;
  int   checks;
  int   cycles;
  int   cycle_limit;
  int   seed;
  row_t rows[$];
  vpn_t walk_vpns[$];

  // status used by the request rows that follow
  prv_t ctx_prv;
  logic ctx_sum;
  logic ctx_mxr;
  logic ctx_satp;

  function automatic logic [VADDR_W-1:0] make_vaddr(logic [8:0] vpn2, logic [8:0] vpn1,
                                                    logic [8:0] vpn0, logic [11:0] offset);
    return {vpn2, vpn1, vpn0, offset};
  endfunction

  // expected translation, bits below the page size come from the vaddr
  function automatic logic [PADDR_W-1:0] map_paddr(ppn_t ppn, level_t level,
                                                   logic [VADDR_W-1:0] va);
    logic [PADDR_W-1:0] keep;
    keep = (PADDR_W'(1) << (PG_IDX_W + PG_LEVEL_W * int'(level))) - PADDR_W'(1);
    return ({ppn, PG_IDX_W'(0)} & ~keep) | (PADDR_W'(va) & keep);
  endfunction

  task automatic set_status(input prv_t prv, input logic sum, input logic mxr,
                            input logic satp);
    ctx_prv  = prv;
    ctx_sum  = sum;
    ctx_mxr  = mxr;
    ctx_satp = satp;
  endtask

  task automatic request_row(input logic [VADDR_W-1:0] va, input cmd_t cmd, input size_t size,
                             input logic miss, input logic [PADDR_W-1:0] paddr,
                             input logic [4:0] faults, input logic walk);
    row_t row;
    row            = '0;
    row.op         = OP_REQ;
    row.vaddr      = va;
    row.cmd        = cmd;
    row.size       = size;
    row.prv        = ctx_prv;
    row.sum        = ctx_sum;
    row.mxr        = ctx_mxr;
    row.satp       = ctx_satp;
    row.exp_miss   = miss;
    row.exp_paddr  = paddr;
    row.exp_faults = faults;
    row.exp_walk   = walk;
    rows.push_back(row);
  endtask

  task automatic refill_row(input vpn_t vpn, input ppn_t ppn, input level_t level,
                            input pte_flags_t flags);
    row_t row;
    row            = '0;
    row.op         = OP_REFILL;
    row.fill_vpn   = vpn;
    row.fill_ppn   = ppn;
    row.fill_level = level;
    row.fill_flags = flags;
    rows.push_back(row);
  endtask

  task automatic fence_row();
    row_t row;
    row    = '0;
    row.op = OP_FENCE;
    rows.push_back(row);
  endtask

  `include "tb_tlb_table.svh"

  tlb_top u_dut (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_valid      (i_req_valid),
    .i_req_vaddr      (i_req_vaddr),
    .i_req_cmd        (i_req_cmd),
    .i_req_size       (i_req_size),
    .i_status_prv     (i_status_prv),
    .i_status_sum     (i_status_sum),
    .i_status_mxr     (i_status_mxr),
    .i_satp_mode_on   (i_satp_mode_on),
    .i_sfence_valid   (i_sfence_valid),
    .o_ptw_req_valid  (o_ptw_req_valid),
    .o_ptw_req_vpn    (o_ptw_req_vpn),
    .i_ptw_resp_valid (i_ptw_resp_valid),
    .i_ptw_resp_vpn   (i_ptw_resp_vpn),
    .i_ptw_resp_ppn   (i_ptw_resp_ppn),
    .i_ptw_resp_level (i_ptw_resp_level),
    .i_ptw_resp_flags (i_ptw_resp_flags),
    .o_resp_valid     (o_resp_valid),
    .o_resp_paddr     (o_resp_paddr),
    .o_resp_miss      (o_resp_miss),
    .o_resp_pf_ld     (o_resp_pf_ld),
    .o_resp_pf_st     (o_resp_pf_st),
    .o_resp_pf_inst   (o_resp_pf_inst),
    .o_resp_ma_ld     (o_resp_ma_ld),
    .o_resp_ma_st     (o_resp_ma_st)
  );

  always #10 i_clk = ~i_clk;

  // walker side, the request is stable at the falling edge of the lookup cycle
  always @(negedge i_clk) begin
    if (o_ptw_req_valid) begin
      walk_vpns.push_back(o_ptw_req_vpn);
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------
  // row driver
  // ------------------------------
  task automatic apply_row(input int idx, input row_t row);
    int errors_before;
    errors_before = errors;
    walk_vpns.delete();
    case (row.op)
      OP_REQ: begin
        i_req_valid    = 1'b1;
        i_req_vaddr    = row.vaddr;
        i_req_cmd      = row.cmd;
        i_req_size     = row.size;
        i_status_prv   = row.prv;
        i_status_sum   = row.sum;
        i_status_mxr   = row.mxr;
        i_satp_mode_on = row.satp;
        @(negedge i_clk);
        i_req_valid = 1'b0;
        @(negedge i_clk);
        check_value("o_resp_valid", 64'(o_resp_valid), 64'd1);
        check_value("o_resp_miss", 64'(o_resp_miss), 64'(row.exp_miss));
        // the address of a miss carries no meaning
        if (!row.exp_miss) begin
          check_value("o_resp_paddr", 64'(o_resp_paddr), 64'(row.exp_paddr));
        end
        check_value("o_resp_pf_ld", 64'(o_resp_pf_ld), 64'(row.exp_faults[4]));
        check_value("o_resp_pf_st", 64'(o_resp_pf_st), 64'(row.exp_faults[3]));
        check_value("o_resp_pf_inst", 64'(o_resp_pf_inst), 64'(row.exp_faults[2]));
        check_value("o_resp_ma_ld", 64'(o_resp_ma_ld), 64'(row.exp_faults[1]));
        check_value("o_resp_ma_st", 64'(o_resp_ma_st), 64'(row.exp_faults[0]));
        check_value("walk requests", 64'(walk_vpns.size()), 64'(row.exp_walk));
        if (walk_vpns.size() == 1) begin
          check_value("o_ptw_req_vpn", 64'(walk_vpns[0]),
                      64'(row.vaddr[VADDR_W-1:PG_IDX_W]));
        end
        $display("row %0d request %s va=%h: %s", idx, row.cmd.name(), row.vaddr,
                 (errors == errors_before) ? "ok" : "failed");
      end
      OP_REFILL: begin
        i_ptw_resp_valid = 1'b1;
        i_ptw_resp_vpn   = row.fill_vpn;
        i_ptw_resp_ppn   = row.fill_ppn;
        i_ptw_resp_level = row.fill_level;
        i_ptw_resp_flags = row.fill_flags;
        @(negedge i_clk);
        i_ptw_resp_valid = 1'b0;
        $display("row %0d refill vpn=%h level=%0d: done", idx, row.fill_vpn, row.fill_level);
      end
      default: begin
        i_sfence_valid = 1'b1;
        @(negedge i_clk);
        i_sfence_valid = 1'b0;
        $display("row %0d fence: done", idx);
      end
    endcase
  endtask

  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_req_valid      = 1'b0;
    i_req_vaddr      = '0;
    i_req_cmd        = CMD_LOAD;
    i_req_size       = '0;
    i_status_prv     = PRV_M;
    i_status_sum     = 1'b0;
    i_status_mxr     = 1'b0;
    i_satp_mode_on   = 1'b0;
    i_sfence_valid   = 1'b0;
    i_ptw_resp_valid = 1'b0;
    i_ptw_resp_vpn   = '0;
    i_ptw_resp_ppn   = '0;
    i_ptw_resp_level = '0;
    i_ptw_resp_flags = '0;
    errors           = 0;
    checks           = 0;
    cycles           = 0;
    seed             = 84;
    build_table();
    cycle_limit = rows.size() * 8 + RESET_CYCLES;

    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_value("o_resp_valid", 64'(o_resp_valid), 64'd0);
    check_value("o_ptw_req_valid", 64'(o_ptw_req_valid), 64'd0);

    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i, rows[i]);
    end

    $display("rows %0d, checks %0d, mismatches %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verification
logic/tlb_pkg.sv
logic/tlb_dec_if.sv
logic/tlb_hit_if.sv
logic/oh_select.sv
logic/tlb_req_decode.sv
logic/tlb_lookup.sv
logic/tlb_resp_gen.sv
logic/tlb_top.sv
verification/tb_tlb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_tlb -f project.f -o sim_tlb

./obj_dir/sim_tlb | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"
